//--- Makefile
TOP := irq_subsystem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f irq_subsystem.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "Verification passed" > /dev/null

clean:
	rm -rf obj_dir

//--- irq_subsystem.f
+incdir+source
source/irq_pkg.sv
source/reg_bus_if.sv
source/host_port.sv
source/interrupt_controller.sv
source/gpio_edge_detect.sv
source/video_timing.sv
source/irq_subsystem.sv
tests/irq_subsystem_tb.sv

//--- source/gpio_edge_detect.sv
`timescale 1ns/1ps

module gpio_edge_detect (
	input  logic CLK,
	input  logic RSTb,
	input  logic gpio,     // asynchronous pin
	output logic irq_req   // one cycle per rising edge
);

logic sync_0;
logic sync_1;
logic prev;
logic rise;

// sync_1 is the first stable copy of the pin
assign rise = sync_1 && !prev;

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		sync_0 <= 1'b0;
		sync_1 <= 1'b0;
	end else begin
		sync_0 <= gpio;
		sync_1 <= sync_0;
	end
end

// edge register, request lands on the third edge after the pin rises
always_ff @(posedge CLK) begin
	if (!RSTb) begin
		prev    <= 1'b0;
		irq_req <= 1'b0;
	end else begin
		prev    <= sync_1;
		irq_req <= rise;
	end
end

endmodule

//--- source/host_port.sv
`timescale 1ns/1ps

module host_port (
	input  logic CLK,
	input  logic RSTb,
	input  logic host_req,
	input  logic host_wr,
	input  irq_pkg::reg_addr_e host_addr,
	input  irq_pkg::reg_data_t host_wdata,
	output irq_pkg::reg_data_t host_rdata,
	output logic host_ack,
	reg_bus_if.master bus
);

typedef enum logic [1:0] {
	ST_IDLE,    // waiting for a request
	ST_ACCESS,  // address on the bus, wr strobe if writing
	ST_ACK      // ack held until the host drops req
} state_t;

state_t state;
irq_pkg::reg_addr_e addr_q;
irq_pkg::reg_data_t wdata_q;
logic wr_q;

assign bus.address = addr_q;
assign bus.wdata   = wdata_q;
assign bus.wr      = wr_q;

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		state    <= ST_IDLE;
		wr_q     <= 1'b0;
		host_ack <= 1'b0;
	end else begin
		case (state)
			ST_IDLE: begin
				if (host_req) begin
					wr_q  <= host_wr;  // single strobe for this access
					state <= ST_ACCESS;
				end
			end
			ST_ACCESS: begin
				wr_q     <= 1'b0;
				host_ack <= 1'b1;
				state    <= ST_ACK;
			end
			ST_ACK: begin
				// a held req keeps ack high and starts nothing new
				if (!host_req) begin
					host_ack <= 1'b0;
					state    <= ST_IDLE;
				end
			end
			default: begin
				wr_q     <= 1'b0;
				host_ack <= 1'b0;
				state    <= ST_IDLE;
			end
		endcase
	end
end

// transaction payload, captured once per access
always_ff @(posedge CLK) begin
	if (state == ST_IDLE && host_req) begin
		addr_q  <= host_addr;
		wdata_q <= host_wdata;
	end
	if (state == ST_ACCESS)
		host_rdata <= bus.rdata;  // valid together with ack
end

endmodule

//--- source/interrupt_controller.sv
`timescale 1ns/1ps
`include "irq_macros.svh"

module interrupt_controller (
	input  logic CLK,
	input  logic RSTb,
	reg_bus_if.slave bus,
	input  irq_pkg::irq_vec_t irq_in,
	output logic interrupt,
	output irq_pkg::irq_id_t irq
);

irq_pkg::irq_vec_t enable;
irq_pkg::irq_vec_t pending;
irq_pkg::irq_vec_t clear_mask;  // registered, applied one edge after the write
irq_pkg::irq_vec_t masked;
irq_pkg::irq_vec_t wr_bits;

logic enable_wr;
logic clear_wr;
logic any_active;
irq_pkg::irq_id_t irq_next;

assign wr_bits   = bus.wdata[`IRQ_N_SOURCES - 1 : 0];
assign enable_wr = bus.wr && (bus.address == irq_pkg::ENABLE);
assign clear_wr  = bus.wr && (bus.address == irq_pkg::CLEAR);

// register reads, upper bits stay zero
always_comb begin
	case (bus.address)
		irq_pkg::ENABLE:  bus.rdata = irq_pkg::reg_data_t'(enable);
		irq_pkg::PENDING: bus.rdata = irq_pkg::reg_data_t'(pending);
		default:          bus.rdata = '0;  // CLEAR and unused addresses
	endcase
end

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		enable     <= '0;
		clear_mask <= '0;
	end else begin
		if (enable_wr)
			enable <= wr_bits;
		clear_mask <= clear_wr ? wr_bits : '0;
	end
end

// a source still high sets its bit again in the same edge it is cleared
always_ff @(posedge CLK) begin
	if (!RSTb)
		pending <= '0;
	else
		pending <= (pending & ~clear_mask) | irq_in;
end

assign masked = pending & enable;

// lowest enabled position wins, so scan from the top down
always_comb begin
	irq_next   = '0;
	any_active = 1'b0;
	for (int i = `IRQ_N_SOURCES - 1; i >= 0; i--) begin
		if (masked[i]) begin
			irq_next   = irq_pkg::irq_id_t'(i + 1);
			any_active = 1'b1;
		end
	end
end

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		interrupt <= 1'b0;
		irq       <= '0;
	end else begin
		interrupt <= any_active;
		irq       <= irq_next;
	end
end

endmodule

//--- source/irq_macros.svh
`ifndef IRQ_MACROS_SVH
`define IRQ_MACROS_SVH

// register bus data width
`define IRQ_DATA_BITS 16

// interrupt sources feeding the controller
`define IRQ_N_SOURCES 5

// irq number width, 0 means no interrupt
`define IRQ_ID_BITS 4

// video timing totals, kept small so a frame is short in simulation
`define VT_H_TOTAL 16  // clocks per line
`define VT_V_TOTAL 8   // lines per frame

`endif

//--- source/irq_pkg.sv
`include "irq_macros.svh"

package irq_pkg;

	// one register data word on the internal bus
	typedef logic [`IRQ_DATA_BITS - 1 : 0] reg_data_t;

	// register map of the interrupt controller
	typedef enum logic [3:0] {
		ENABLE  = 4'h0,  // source enable mask
		CLEAR   = 4'h1,  // write a mask to clear pending bits
		PENDING = 4'h2   // latched sources, read only
	} reg_addr_e;

	// one bit per interrupt source
	typedef logic [`IRQ_N_SOURCES - 1 : 0] irq_vec_t;

	// bit positions in irq_vec_t, lowest position wins
	typedef enum int unsigned {
		HSYNC     = 0,
		VSYNC     = 1,
		AUDIO     = 2,
		SPI_FLASH = 3,
		GPIO      = 4
	} irq_src_e;

	// source position plus one, 0 when nothing is active
	typedef logic [`IRQ_ID_BITS - 1 : 0] irq_id_t;

endpackage

//--- source/irq_subsystem.sv
`timescale 1ns/1ps

module irq_subsystem (
	input  logic CLK,
	input  logic RSTb,
	input  logic host_req,
	input  logic host_wr,
	input  irq_pkg::reg_addr_e host_addr,
	input  irq_pkg::reg_data_t host_wdata,
	output irq_pkg::reg_data_t host_rdata,
	output logic host_ack,
	input  logic gpio,
	input  logic irq_audio,
	input  logic irq_spi_flash,
	output logic interrupt,
	output irq_pkg::irq_id_t irq
);

reg_bus_if bus0 ();

logic hsync_irq;
logic vsync_irq;
logic gpio_irq;
irq_pkg::irq_vec_t irq_src;

// source vector in irq_src_e order
assign irq_src[irq_pkg::HSYNC]     = hsync_irq;
assign irq_src[irq_pkg::VSYNC]     = vsync_irq;
assign irq_src[irq_pkg::AUDIO]     = irq_audio;
assign irq_src[irq_pkg::SPI_FLASH] = irq_spi_flash;
assign irq_src[irq_pkg::GPIO]      = gpio_irq;

host_port host_port0 (
	.CLK        (CLK),
	.RSTb       (RSTb),
	.host_req   (host_req),
	.host_wr    (host_wr),
	.host_addr  (host_addr),
	.host_wdata (host_wdata),
	.host_rdata (host_rdata),
	.host_ack   (host_ack),
	.bus        (bus0.master)
);

interrupt_controller irq_ctrl0 (
	.CLK       (CLK),
	.RSTb      (RSTb),
	.bus       (bus0.slave),
	.irq_in    (irq_src),
	.interrupt (interrupt),
	.irq       (irq)
);

gpio_edge_detect gpio_edge0 (
	.CLK     (CLK),
	.RSTb    (RSTb),
	.gpio    (gpio),
	.irq_req (gpio_irq)
);

video_timing video_timing0 (
	.CLK       (CLK),
	.RSTb      (RSTb),
	.hsync_irq (hsync_irq),
	.vsync_irq (vsync_irq)
);

endmodule

//--- source/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;

	irq_pkg::reg_addr_e address;  // register select
	irq_pkg::reg_data_t wdata;
	irq_pkg::reg_data_t rdata;    // combinational from address
	logic wr;                     // one cycle write strobe

	modport master (
		output address,
		output wdata,
		output wr,
		input  rdata
	);

	modport slave (
		input  address,
		input  wdata,
		input  wr,
		output rdata
	);

endinterface

//--- source/video_timing.sv
`timescale 1ns/1ps
`include "irq_macros.svh"

module video_timing (
	input  logic CLK,
	input  logic RSTb,
	output logic hsync_irq,  // once per line
	output logic vsync_irq   // once per frame, together with hsync
);

localparam int H_BITS = $clog2(`VT_H_TOTAL);
localparam int V_BITS = $clog2(`VT_V_TOTAL);

localparam logic [H_BITS - 1 : 0] H_LAST = H_BITS'(`VT_H_TOTAL - 1);
localparam logic [V_BITS - 1 : 0] V_LAST = V_BITS'(`VT_V_TOTAL - 1);

logic [H_BITS - 1 : 0] h_cnt;  // clock within line
logic [V_BITS - 1 : 0] v_cnt;  // line within frame
logic h_wrap;
logic v_wrap;

assign h_wrap = (h_cnt == H_LAST);
assign v_wrap = h_wrap && (v_cnt == V_LAST);

always_ff @(posedge CLK) begin
	if (!RSTb) begin
		h_cnt <= '0;
		v_cnt <= '0;
	end else begin
		if (h_wrap) begin
			h_cnt <= '0;
			if (v_wrap)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end
end

// requests are high in the cycle the counters read zero
always_ff @(posedge CLK) begin
	if (!RSTb) begin
		hsync_irq <= 1'b0;
		vsync_irq <= 1'b0;
	end else begin
		hsync_irq <= h_wrap;
		vsync_irq <= v_wrap;
	end
end

endmodule

//--- tests/irq_subsystem_tb.sv
`timescale 1ns/1ps
`include "irq_macros.svh"

module irq_subsystem_tb;

localparam int FRAME_CLKS    = `VT_H_TOTAL * `VT_V_TOTAL;
localparam int ACK_LIMIT     = 16;  // clocks allowed for each handshake phase

localparam irq_pkg::reg_data_t SRC_BITS = irq_pkg::reg_data_t'((1 << `IRQ_N_SOURCES) - 1);
localparam irq_pkg::irq_vec_t  SYNC_BITS =
	irq_pkg::irq_vec_t'((1 << irq_pkg::HSYNC) | (1 << irq_pkg::VSYNC));
localparam irq_pkg::irq_vec_t  AUD = irq_pkg::irq_vec_t'(1 << irq_pkg::AUDIO);
localparam irq_pkg::irq_vec_t  SPI = irq_pkg::irq_vec_t'(1 << irq_pkg::SPI_FLASH);
localparam irq_pkg::irq_vec_t  GPI = irq_pkg::irq_vec_t'(1 << irq_pkg::GPIO);
localparam irq_pkg::irq_vec_t  VSY = irq_pkg::irq_vec_t'(1 << irq_pkg::VSYNC);
localparam irq_pkg::reg_addr_e UNUSED_ADDR = irq_pkg::reg_addr_e'(4'h9);

logic CLK;
logic RSTb;
logic host_req;
logic host_wr;
irq_pkg::reg_addr_e host_addr;
irq_pkg::reg_data_t host_wdata;
irq_pkg::reg_data_t host_rdata;
logic host_ack;
logic gpio;
logic irq_audio;
logic irq_spi_flash;
logic interrupt;
irq_pkg::irq_id_t irq;

// stimulus table with one entry per index
string              step_name[$];
irq_pkg::reg_data_t step_enable[$];
irq_pkg::irq_vec_t  step_pulse[$];    // pins to pulse
irq_pkg::irq_vec_t  step_clear[$];    // mask written to CLEAR or 0 for none
irq_pkg::irq_vec_t  step_pending[$];  // sync bits not compared
irq_pkg::irq_id_t   step_irq[$];
logic               step_int[$];

irq_subsystem dut0 (
	.CLK           (CLK),
	.RSTb          (RSTb),
	.host_req      (host_req),
	.host_wr       (host_wr),
	.host_addr     (host_addr),
	.host_wdata    (host_wdata),
	.host_rdata    (host_rdata),
	.host_ack      (host_ack),
	.gpio          (gpio),
	.irq_audio     (irq_audio),
	.irq_spi_flash (irq_spi_flash),
	.interrupt     (interrupt),
	.irq           (irq)
);

initial begin
	CLK = 1'b0;
	forever #5 CLK = ~CLK;
end

task automatic stop_on_error(input string msg);
	$display("%s", msg);
	$display("Verification failed");
	$fatal(1, "stopped at first error");
endtask

// irq number is the source position plus one
function automatic irq_pkg::irq_id_t id_of(input irq_pkg::irq_src_e src);
	return irq_pkg::irq_id_t'(src + 1);
endfunction

task automatic check_data(input string name, input irq_pkg::reg_data_t exp,
		input irq_pkg::reg_data_t act);
	if (act !== exp)
		stop_on_error($sformatf("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act));
endtask

task automatic check_irq(input string name, input irq_pkg::irq_id_t exp,
		input irq_pkg::irq_id_t act);
	if (act !== exp)
		stop_on_error($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp)
		stop_on_error($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
endtask

task automatic wait_ack(input logic level);
	int n;
	n = 0;
	while (host_ack !== level) begin
		if (n == ACK_LIMIT)
			stop_on_error($sformatf("host_ack did not %s within %0d clocks",
				level ? "rise" : "fall", ACK_LIMIT));
		@(negedge CLK);
		n++;
	end
endtask

// one four-phase transaction with read data taken while ack is high
task automatic host_access(input logic wr, input irq_pkg::reg_addr_e addr,
		input irq_pkg::reg_data_t wdata, output irq_pkg::reg_data_t rdata);
	@(posedge CLK);
	host_req   <= 1'b1;
	host_wr    <= wr;
	host_addr  <= addr;
	host_wdata <= wdata;
	wait_ack(1'b1);
	rdata = host_rdata;
	@(posedge CLK);
	host_req <= 1'b0;
	host_wr  <= 1'b0;
	wait_ack(1'b0);
endtask

task automatic host_write(input irq_pkg::reg_addr_e addr, input irq_pkg::reg_data_t data);
	irq_pkg::reg_data_t unused_rd;
	host_access(1'b1, addr, data, unused_rd);
endtask

task automatic host_read(input irq_pkg::reg_addr_e addr, output irq_pkg::reg_data_t data);
	host_access(1'b0, addr, '0, data);
endtask

task automatic pulse_pins(input irq_pkg::irq_vec_t pins);
	int gap;
	gap = 1 + int'($urandom % 4);  // random gpio high time
	@(posedge CLK);
	irq_audio     <= pins[irq_pkg::AUDIO];
	irq_spi_flash <= pins[irq_pkg::SPI_FLASH];
	gpio          <= pins[irq_pkg::GPIO];
	@(posedge CLK);
	irq_audio     <= 1'b0;
	irq_spi_flash <= 1'b0;
	repeat (gap) @(posedge CLK);
	gpio <= 1'b0;
	repeat (4) @(posedge CLK);  // gpio request through synchronizer and edge register
endtask

task automatic wait_interrupt(input string name, input int limit);
	int n;
	n = 0;
	while (interrupt !== 1'b1) begin
		if (n == limit)
			stop_on_error($sformatf("%s: interrupt did not rise within %0d clocks", name, limit));
		@(negedge CLK);
		n++;
	end
endtask

task automatic add_step(input string name, input irq_pkg::reg_data_t en,
		input irq_pkg::irq_vec_t pulse, input irq_pkg::irq_vec_t clr,
		input irq_pkg::irq_vec_t pend, input irq_pkg::irq_id_t id, input logic intr);
	step_name.push_back(name);
	step_enable.push_back(en);
	step_pulse.push_back(pulse);
	step_clear.push_back(clr);
	step_pending.push_back(pend);
	step_irq.push_back(id);
	step_int.push_back(intr);
endtask

task automatic fill_table();
	add_step("gpio_pending", 16'h0000, GPI, '0, GPI, '0, 1'b0);
	add_step("gpio_clear", 16'h0000, '0, GPI, '0, '0, 1'b0);
	add_step("enable_readback", 16'hFFFC, '0, '0, '0, '0, 1'b0);
	add_step("priority_audio", 16'h001C, AUD | SPI | GPI, '0, AUD | SPI | GPI,
		id_of(irq_pkg::AUDIO), 1'b1);
	add_step("mask_audio", 16'h0018, '0, '0, AUD | SPI | GPI, id_of(irq_pkg::SPI_FLASH), 1'b1);
	add_step("mask_spi_flash", 16'h0010, '0, '0, AUD | SPI | GPI, id_of(irq_pkg::GPIO), 1'b1);
	add_step("none_enabled", 16'h0000, '0, '0, AUD | SPI | GPI, '0, 1'b0);
	add_step("clear_all", 16'h001C, '0, AUD | SPI | GPI, '0, '0, 1'b0);
endtask

task automatic run_step(input int i);
	irq_pkg::reg_data_t rd;
	host_write(irq_pkg::ENABLE, step_enable[i]);
	host_read(irq_pkg::ENABLE, rd);
	check_data({step_name[i], " enable"}, step_enable[i] & SRC_BITS, rd);
	pulse_pins(step_pulse[i]);
	if (step_clear[i] != '0) begin
		host_write(irq_pkg::CLEAR, irq_pkg::reg_data_t'(step_clear[i]));
		repeat (2) @(posedge CLK);
	end
	host_read(irq_pkg::PENDING, rd);
	check_data({step_name[i], " pending"}, irq_pkg::reg_data_t'(step_pending[i]),
		rd & ~irq_pkg::reg_data_t'(SYNC_BITS));
	@(negedge CLK);
	check_bit({step_name[i], " interrupt"}, step_int[i], interrupt);
	check_irq({step_name[i], " irq"}, step_irq[i], irq);
endtask

initial begin
	irq_pkg::reg_data_t rd;
	void'($urandom(56145));
	RSTb          = 1'b0;
	host_req      = 1'b0;
	host_wr       = 1'b0;
	host_addr     = irq_pkg::ENABLE;
	host_wdata    = '0;
	gpio          = 1'b0;
	irq_audio     = 1'b0;
	irq_spi_flash = 1'b0;
	fill_table();
	repeat (8) @(posedge CLK);
	RSTb <= 1'b1;

	@(negedge CLK);
	check_bit("reset interrupt", 1'b0, interrupt);
	check_irq("reset irq", '0, irq);
	host_read(irq_pkg::ENABLE, rd);
	check_data("reset enable", '0, rd);
	host_read(UNUSED_ADDR, rd);
	check_data("reset unused read", '0, rd);

	for (int i = 0; i < step_name.size(); i++)
		run_step(i);

	host_write(UNUSED_ADDR, 16'hFFFF);
	host_read(irq_pkg::ENABLE, rd);
	check_data("unused write enable", step_enable[step_name.size() - 1] & SRC_BITS, rd);
	host_read(UNUSED_ADDR, rd);
	check_data("unused write read", '0, rd);

	// vsync alone gives one request per frame
	host_write(irq_pkg::ENABLE, '0);
	host_write(irq_pkg::CLEAR, SRC_BITS);
	host_write(irq_pkg::ENABLE, irq_pkg::reg_data_t'(VSY));
	wait_interrupt("vsync first", FRAME_CLKS + 3);
	check_irq("vsync first irq", id_of(irq_pkg::VSYNC), irq);
	host_write(irq_pkg::CLEAR, irq_pkg::reg_data_t'(VSY));
	repeat (2) @(negedge CLK);
	check_bit("vsync cleared", 1'b0, interrupt);
	wait_interrupt("vsync next", FRAME_CLKS + 3);
	check_irq("vsync next irq", id_of(irq_pkg::VSYNC), irq);

	$display("Verification passed");
	$finish;
end

initial begin
	int limit;
	wait (RSTb === 1'b1);  // table is filled before reset ends
	limit = step_name.size() * FRAME_CLKS * 4;
	repeat (limit) @(posedge CLK);
	stop_on_error($sformatf("watchdog expired after %0d clocks", limit));
end

endmodule
